// File: compile.f
design/fsab_pkg.sv
design/arb_pkg.sv
design/fsab_gray_sync.sv
design/fsab_async_fifo.sv
design/fsab_arbiter_fifo.sv
design/fsab_arbiter.sv
design/fsab_arb_top.sv
tb/fsab_arb_checker.sv
tb/tb_fsab_arb.sv

// File: design/arb_pkg.sv
package arb_pkg;
	import fsab_pkg::*;

	localparam int arb_masters = 2; // Master ports on the arbiter.

	// Header word is mode, did, subdid, addr, len from msb down.
	localparam int arb_rfif_w = $bits(fsab_mode_t) + 2 * $bits(fsab_did_t) +
		$bits(fsab_addr_t) + $bits(fsab_len_t);
	localparam int arb_dfif_w = $bits(fsab_data_t) + $bits(fsab_mask_t); // Data over mask.

	// Room for every outstanding request at full length.
	localparam int arb_dfif_depth = fsab_initial_credits * fsab_len_max;
	typedef logic [5:0] arb_dfif_ptr_t; // Address plus wrap bit.

	typedef logic [0:0] arb_grant_t; // Master index.

	typedef enum logic [1:0] {arb_idle, arb_start, arb_busy} arb_state_t;
endpackage

// File: design/fsab_arb_top.sv
`timescale 1ns/1ps

module fsab_arb_top
	import fsab_pkg::*;
	import arb_pkg::*;
(
	input  logic       oclk,
	input  logic       oclk_rst_b,

	input  logic       m0_clk, // Master 0.
	input  logic       m0_rst_b,
	input  logic       m0_valid,
	input  fsab_mode_t m0_mode,
	input  fsab_did_t  m0_did,
	input  fsab_did_t  m0_subdid,
	input  fsab_addr_t m0_addr,
	input  fsab_len_t  m0_len,
	input  fsab_data_t m0_data,
	input  fsab_mask_t m0_mask,
	output logic       m0_credit,

	input  logic       m1_clk, // Master 1.
	input  logic       m1_rst_b,
	input  logic       m1_valid,
	input  fsab_mode_t m1_mode,
	input  fsab_did_t  m1_did,
	input  fsab_did_t  m1_subdid,
	input  fsab_addr_t m1_addr,
	input  fsab_len_t  m1_len,
	input  fsab_data_t m1_data,
	input  fsab_mask_t m1_mask,
	output logic       m1_credit,

	output logic       out_valid,
	output fsab_mode_t out_mode,
	output fsab_did_t  out_did,
	output fsab_did_t  out_subdid,
	output fsab_addr_t out_addr,
	output fsab_len_t  out_len,
	output fsab_data_t out_data,
	output fsab_mask_t out_mask
);
	logic [arb_masters-1:0] empty_b;
	logic [arb_masters-1:0] active;
	logic [arb_masters-1:0] start_trans;

	logic f0_valid, f1_valid;
	fsab_mode_t f0_mode, f1_mode;
	fsab_did_t f0_did, f1_did;
	fsab_did_t f0_subdid, f1_subdid;
	fsab_addr_t f0_addr, f1_addr;
	fsab_len_t f0_len, f1_len;
	fsab_data_t f0_data, f1_data;
	fsab_mask_t f0_mask, f1_mask;

	fsab_arbiter_fifo u_fifo0 (
		.iclk(m0_clk), .iclk_rst_b(m0_rst_b), .oclk(oclk), .oclk_rst_b(oclk_rst_b),
		.inp_valid(m0_valid), .inp_mode(m0_mode), .inp_did(m0_did), .inp_subdid(m0_subdid),
		.inp_addr(m0_addr), .inp_len(m0_len), .inp_data(m0_data), .inp_mask(m0_mask),
		.inp_credit(m0_credit),
		.out_valid(f0_valid), .out_mode(f0_mode), .out_did(f0_did), .out_subdid(f0_subdid),
		.out_addr(f0_addr), .out_len(f0_len), .out_data(f0_data), .out_mask(f0_mask),
		.empty_b(empty_b[0]), .start_trans(start_trans[0]), .active(active[0])
	);

	fsab_arbiter_fifo u_fifo1 (
		.iclk(m1_clk), .iclk_rst_b(m1_rst_b), .oclk(oclk), .oclk_rst_b(oclk_rst_b),
		.inp_valid(m1_valid), .inp_mode(m1_mode), .inp_did(m1_did), .inp_subdid(m1_subdid),
		.inp_addr(m1_addr), .inp_len(m1_len), .inp_data(m1_data), .inp_mask(m1_mask),
		.inp_credit(m1_credit),
		.out_valid(f1_valid), .out_mode(f1_mode), .out_did(f1_did), .out_subdid(f1_subdid),
		.out_addr(f1_addr), .out_len(f1_len), .out_data(f1_data), .out_mask(f1_mask),
		.empty_b(empty_b[1]), .start_trans(start_trans[1]), .active(active[1])
	);

	// Grant and bus mux.
	fsab_arbiter u_arbiter (
		.oclk(oclk), .oclk_rst_b(oclk_rst_b),
		.empty_b(empty_b), .active(active), .start_trans(start_trans),
		.f0_valid(f0_valid), .f0_mode(f0_mode), .f0_did(f0_did), .f0_subdid(f0_subdid),
		.f0_addr(f0_addr), .f0_len(f0_len), .f0_data(f0_data), .f0_mask(f0_mask),
		.f1_valid(f1_valid), .f1_mode(f1_mode), .f1_did(f1_did), .f1_subdid(f1_subdid),
		.f1_addr(f1_addr), .f1_len(f1_len), .f1_data(f1_data), .f1_mask(f1_mask),
		.out_valid(out_valid), .out_mode(out_mode), .out_did(out_did),
		.out_subdid(out_subdid), .out_addr(out_addr), .out_len(out_len),
		.out_data(out_data), .out_mask(out_mask)
	);
endmodule

// File: design/fsab_arbiter.sv
`timescale 1ns/1ps

module fsab_arbiter
	import fsab_pkg::*;
	import arb_pkg::*;
(
	input  logic                   oclk,
	input  logic                   oclk_rst_b,
	input  logic [arb_masters-1:0] empty_b,
	input  logic [arb_masters-1:0] active,
	output logic [arb_masters-1:0] start_trans,

	input  logic       f0_valid,
	input  fsab_mode_t f0_mode,
	input  fsab_did_t  f0_did,
	input  fsab_did_t  f0_subdid,
	input  fsab_addr_t f0_addr,
	input  fsab_len_t  f0_len,
	input  fsab_data_t f0_data,
	input  fsab_mask_t f0_mask,

	input  logic       f1_valid,
	input  fsab_mode_t f1_mode,
	input  fsab_did_t  f1_did,
	input  fsab_did_t  f1_subdid,
	input  fsab_addr_t f1_addr,
	input  fsab_len_t  f1_len,
	input  fsab_data_t f1_data,
	input  fsab_mask_t f1_mask,

	output logic       out_valid,
	output fsab_mode_t out_mode,
	output fsab_did_t  out_did,
	output fsab_did_t  out_subdid,
	output fsab_addr_t out_addr,
	output fsab_len_t  out_len,
	output fsab_data_t out_data,
	output fsab_mask_t out_mask
);
	arb_state_t state;
	arb_grant_t grant; // Last master started.
	arb_grant_t next_idx;
	arb_grant_t pick;
	logic any_req;

	// Round robin, the master after the last grant goes first.
	assign next_idx = grant + 1'b1;
	assign pick = empty_b[next_idx] ? next_idx : grant;
	assign any_req = |empty_b;

	always_comb begin
		start_trans = '0;
		if ((state == arb_idle) && any_req)
			start_trans[pick] = 1'b1; // Single cycle, idle only.
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			state <= arb_idle;
			grant <= arb_grant_t'(arb_masters - 1); // Master 0 wins first.
		end else begin
			case (state)
				arb_idle: begin
					if (any_req) begin
						grant <= pick;
						state <= arb_start;
					end
				end
				arb_start: if (active[grant]) state <= arb_busy;
				arb_busy: if (!active[grant]) state <= arb_idle; // Transfer done.
				default: state <= arb_idle;
			endcase
		end
	end

	// Output mux follows the held grant.
	always_comb begin
		if (grant == arb_grant_t'(1)) begin
			out_valid = f1_valid;
			out_mode = f1_mode;
			out_did = f1_did;
			out_subdid = f1_subdid;
			out_addr = f1_addr;
			out_len = f1_len;
			out_data = f1_data;
			out_mask = f1_mask;
		end else begin
			out_valid = f0_valid;
			out_mode = f0_mode;
			out_did = f0_did;
			out_subdid = f0_subdid;
			out_addr = f0_addr;
			out_len = f0_len;
			out_data = f0_data;
			out_mask = f0_mask;
		end
	end
endmodule

// File: design/fsab_arbiter_fifo.sv
`timescale 1ns/1ps

module fsab_arbiter_fifo
	import fsab_pkg::*;
	import arb_pkg::*;
(
	input  logic       iclk,
	input  logic       iclk_rst_b,
	input  logic       oclk,
	input  logic       oclk_rst_b,

	input  logic       inp_valid, // Master side, iclk.
	input  fsab_mode_t inp_mode,
	input  fsab_did_t  inp_did,
	input  fsab_did_t  inp_subdid,
	input  fsab_addr_t inp_addr,
	input  fsab_len_t  inp_len,
	input  fsab_data_t inp_data,
	input  fsab_mask_t inp_mask,
	output logic       inp_credit,

	output logic       out_valid, // Bus side, oclk.
	output fsab_mode_t out_mode,
	output fsab_did_t  out_did,
	output fsab_did_t  out_subdid,
	output fsab_addr_t out_addr,
	output fsab_len_t  out_len,
	output fsab_data_t out_data,
	output fsab_mask_t out_mask,

	output logic       empty_b, // Arbiter handshake, oclk.
	input  logic       start_trans,
	output logic       active
);
	fsab_len_t inp_rem; // Write beats still to come after this one.
	logic inp_hdr;
	fsab_credits_t credit_count_iclk; // Credits handed back so far.
	fsab_credits_t credit_gray_iclk;
	logic credit_oclk;

	logic rfif_empty;
	logic dfif_empty;
	logic rfif_rd;
	logic dfif_rd;
	logic [arb_rfif_w-1:0] rfif_rdata;
	logic [arb_dfif_w-1:0] dfif_rdata;
	logic hdr_q; // Header on rfif_rdata this cycle.
	logic busy; // Draining write data.
	logic busy_q;
	fsab_len_t beats_left; // Data reads still to issue.

	// Any valid beat outside a write is a new header.
	assign inp_hdr = inp_valid && (inp_rem == '0);

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			inp_rem <= '0;
		end else if (inp_hdr && (inp_mode == fsab_write)) begin
			inp_rem <= inp_len - 1'b1; // First word rides with the header.
		end else if (inp_valid && (inp_rem != '0)) begin
			inp_rem <= inp_rem - 1'b1;
		end
	end

	fsab_async_fifo #(
		.width(arb_rfif_w),
		.depth(fsab_initial_credits),
		.ptr_w($bits(fsab_credits_t))
	) u_rfif (
		.wr_clk(iclk),
		.wr_rst_b(iclk_rst_b),
		.wr_en(inp_hdr),
		.wr_data({inp_mode, inp_did, inp_subdid, inp_addr, inp_len}),
		.rd_clk(oclk),
		.rd_rst_b(oclk_rst_b),
		.rd_en(rfif_rd),
		.rd_data(rfif_rdata),
		.empty(rfif_empty)
	);

	// Every valid beat lands here, reads included.
	fsab_async_fifo #(
		.width(arb_dfif_w),
		.depth(arb_dfif_depth),
		.ptr_w($bits(arb_dfif_ptr_t))
	) u_dfif (
		.wr_clk(iclk),
		.wr_rst_b(iclk_rst_b),
		.wr_en(inp_valid),
		.wr_data({inp_data, inp_mask}),
		.rd_clk(oclk),
		.rd_rst_b(oclk_rst_b),
		.rd_en(dfif_rd),
		.rd_data(dfif_rdata),
		.empty(dfif_empty)
	);

	assign {out_mode, out_did, out_subdid, out_addr, out_len} = rfif_rdata;
	assign {out_data, out_mask} = dfif_rdata;

	// Header and first word must both be visible.
	assign empty_b = !rfif_empty && !dfif_empty;
	assign rfif_rd = start_trans && empty_b && !active;
	// Header read always takes a data entry too.
	assign dfif_rd = rfif_rd || (busy && (beats_left != '0) && !dfif_empty);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			hdr_q <= 1'b0;
			out_valid <= 1'b0;
			busy <= 1'b0;
			busy_q <= 1'b0;
			beats_left <= '0;
		end else begin
			hdr_q <= rfif_rd;
			out_valid <= dfif_rd; // Beat appears one cycle after its read.
			busy_q <= busy;
			if (hdr_q && (out_mode == fsab_write)) begin
				busy <= 1'b1;
				beats_left <= out_len - 1'b1;
			end else if (busy) begin
				if (dfif_rd)
					beats_left <= beats_left - 1'b1;
				else if (beats_left == '0)
					busy <= 1'b0; // Last beat already out.
			end
		end
	end

	assign active = hdr_q || busy || busy_q;

	// Credit at end of a write, or right after a read header.
	assign credit_oclk = (busy_q && !busy) || (hdr_q && (out_mode == fsab_read));

	// Credit count back to the master clock.
	fsab_gray_sync #(.w($bits(fsab_credits_t))) u_credit_sync (
		.src_clk(oclk),
		.src_rst_b(oclk_rst_b),
		.inc(credit_oclk),
		.dst_clk(iclk),
		.dst_rst_b(iclk_rst_b),
		.src_count(),
		.dst_gray(credit_gray_iclk)
	);

	// One pulse per step the synchronized count is ahead.
	assign inp_credit = credit_gray_iclk != (credit_count_iclk ^ (credit_count_iclk >> 1));

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b)
			credit_count_iclk <= '0;
		else if (inp_credit)
			credit_count_iclk <= credit_count_iclk + 1'b1;
	end
endmodule

// File: design/fsab_async_fifo.sv
`timescale 1ns/1ps

module fsab_async_fifo #(
	parameter int width = 8,
	parameter int depth = 4, // Power of two.
	parameter int ptr_w = $clog2(depth) + 1
) (
	input  logic             wr_clk,
	input  logic             wr_rst_b,
	input  logic             wr_en,
	input  logic [width-1:0] wr_data,
	input  logic             rd_clk,
	input  logic             rd_rst_b,
	input  logic             rd_en,
	output logic [width-1:0] rd_data,
	output logic             empty
);
	localparam int addr_w = ptr_w - 1;

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr; // Binary, write domain.
	logic [ptr_w-1:0] wr_gray_rd; // Write pointer as seen in the read domain.
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] rd_gray;

	// Write pointer crossing.
	fsab_gray_sync #(.w(ptr_w)) u_wr_ptr_sync (
		.src_clk(wr_clk),
		.src_rst_b(wr_rst_b),
		.inc(wr_en),
		.dst_clk(rd_clk),
		.dst_rst_b(rd_rst_b),
		.src_count(wr_ptr),
		.dst_gray(wr_gray_rd)
	);

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			mem[wr_ptr[addr_w-1:0]] <= wr_data;
	end

	// Only the write side lags, so empty can linger but never clears early.
	assign rd_gray = rd_ptr ^ (rd_ptr >> 1);
	assign empty = (rd_gray == wr_gray_rd);

	always_ff @(posedge rd_clk or negedge rd_rst_b) begin
		if (!rd_rst_b)
			rd_ptr <= '0;
		else if (rd_en)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Registered read port, holds between reads.
	always_ff @(posedge rd_clk) begin
		if (rd_en)
			rd_data <= mem[rd_ptr[addr_w-1:0]];
	end
endmodule

// File: design/fsab_gray_sync.sv
`timescale 1ns/1ps

module fsab_gray_sync #(
	parameter int w = 3 // Counter width.
) (
	input  logic         src_clk,
	input  logic         src_rst_b,
	input  logic         inc,
	input  logic         dst_clk,
	input  logic         dst_rst_b,
	output logic [w-1:0] src_count,
	output logic [w-1:0] dst_gray
);
	logic [w-1:0] count_next;
	logic [w-1:0] src_gray; // Always the gray form of src_count.
	logic [w-1:0] sync_s1;

	assign count_next = src_count + w'(inc);

	// Gray value comes straight from a flop, so only one bit moves per step.
	always_ff @(posedge src_clk or negedge src_rst_b) begin
		if (!src_rst_b) begin
			src_count <= '0;
			src_gray <= '0;
		end else begin
			src_count <= count_next;
			src_gray <= count_next ^ (count_next >> 1);
		end
	end

	// Two-flop synchronizer.
	always_ff @(posedge dst_clk or negedge dst_rst_b) begin
		if (!dst_rst_b) begin
			sync_s1 <= '0;
			dst_gray <= '0;
		end else begin
			sync_s1 <= src_gray;
			dst_gray <= sync_s1; // Settled copy.
		end
	end
endmodule

// File: design/fsab_pkg.sv
package fsab_pkg;
	typedef logic fsab_mode_t; // Request direction.
	localparam fsab_mode_t fsab_read = 1'b0;
	localparam fsab_mode_t fsab_write = 1'b1;

	typedef logic [3:0] fsab_did_t; // Device id, also used for subdid.
	typedef logic [31:0] fsab_addr_t;
	typedef logic [3:0] fsab_len_t; // Burst length in beats.
	typedef logic [63:0] fsab_data_t;
	typedef logic [7:0] fsab_mask_t; // One bit per data byte.

	// Longest burst a master may issue.
	localparam int fsab_len_max = 8;
	localparam int fsab_initial_credits = 4; // Held by each master after reset.

	// Credit counter and request FIFO pointer.
	// One bit wider than a full credit set, for wrap detection.
	typedef logic [2:0] fsab_credits_t;
endpackage

// File: run.sh
#!/bin/sh
# Build the FSAB arbiter testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fsab_arb \
	-Mdir obj_dir -o sim_fsab_arb -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fsab_arb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation PASSED" "$log"; then
	exit 0
fi
exit 1

// File: tb/fsab_arb_checker.sv
`timescale 1ns/1ps

module fsab_arb_checker
	import fsab_pkg::*;
	import arb_pkg::*;
(
	input logic iclk,
	input logic iclk_rst_b,
	input logic oclk,
	input logic oclk_rst_b,
	input logic inp_hdr,
	input logic inp_valid,
	input logic rfif_rd,
	input logic dfif_rd,
	input logic start_trans,
	input logic active
);
	int rfif_wr_cnt; // Headers written, master side.
	int dfif_wr_cnt;
	int rfif_rd_cnt; // Entries read, bus side.
	int dfif_rd_cnt;

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			rfif_wr_cnt <= 0;
			dfif_wr_cnt <= 0;
		end else begin
			rfif_wr_cnt <= rfif_wr_cnt + int'(inp_hdr);
			dfif_wr_cnt <= dfif_wr_cnt + int'(inp_valid);
		end
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rfif_rd_cnt <= 0;
			dfif_rd_cnt <= 0;
		end else begin
			rfif_rd_cnt <= rfif_rd_cnt + int'(rfif_rd);
			dfif_rd_cnt <= dfif_rd_cnt + int'(dfif_rd);
		end
	end

	// Reads stay behind the writes already made on the master side.
	a_rfif_rd_empty: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		rfif_rd |-> (rfif_wr_cnt > rfif_rd_cnt)) else $error("rfif read while empty");
	a_dfif_rd_empty: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		dfif_rd |-> (dfif_wr_cnt > dfif_rd_cnt)) else $error("dfif read while empty");

	// Occupancy seen from the write side, read count may lag.
	a_rfif_full: assert property (@(posedge iclk) disable iff (!iclk_rst_b)
		inp_hdr |-> (rfif_wr_cnt - rfif_rd_cnt) < fsab_initial_credits)
		else $error("rfif written while full");
	a_dfif_full: assert property (@(posedge iclk) disable iff (!iclk_rst_b)
		inp_valid |-> (dfif_wr_cnt - dfif_rd_cnt) < arb_dfif_depth)
		else $error("dfif written while full");

	a_start_idle: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		start_trans |-> !active) else $error("start_trans while active");
	a_start_pulse: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		start_trans |=> !start_trans) else $error("start_trans longer than one cycle");
endmodule

// File: tb/tb_fsab_arb.sv
`timescale 1ns/1ps

module tb_fsab_arb
	import fsab_pkg::*;
();
	localparam int credit_timeout = 2000; // Master clocks.
	localparam int drain_timeout = 6000; // Bus clocks.

	typedef struct packed {
		fsab_mode_t mode;
		fsab_did_t did;
		fsab_did_t subdid;
		fsab_addr_t addr;
		fsab_len_t len;
		fsab_data_t data;
		fsab_mask_t mask;
	} beat_t;

	logic oclk;
	logic oclk_rst_b;
	logic m0_clk;
	logic m0_rst_b;
	logic m1_clk;
	logic m1_rst_b;
	logic m_valid [2]; // Master drive, index is did.
	fsab_mode_t m_mode [2];
	fsab_did_t m_did [2];
	fsab_did_t m_subdid [2];
	fsab_addr_t m_addr [2];
	fsab_len_t m_len [2];
	fsab_data_t m_data [2];
	fsab_mask_t m_mask [2];
	logic m0_credit;
	logic m1_credit;
	logic out_valid;
	fsab_mode_t out_mode;
	fsab_did_t out_did;
	fsab_did_t out_subdid;
	fsab_addr_t out_addr;
	fsab_len_t out_len;
	fsab_data_t out_data;
	fsab_mask_t out_mask;

	beat_t exp_q0 [$]; // Expected beats, master 0.
	beat_t exp_q1 [$];
	int credits [2]; // Credits held by each master.
	int stalls [2]; // Requests that found no credit.
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int tests_failed = 0;
	int burst_left = 0; // Beats still due in the current burst.
	fsab_did_t burst_did;
	string cur_test = "setup";

	fsab_arb_top u_fsab_arb_top (
		.oclk(oclk), .oclk_rst_b(oclk_rst_b),
		.m0_clk(m0_clk), .m0_rst_b(m0_rst_b), .m0_valid(m_valid[0]), .m0_mode(m_mode[0]),
		.m0_did(m_did[0]), .m0_subdid(m_subdid[0]), .m0_addr(m_addr[0]), .m0_len(m_len[0]),
		.m0_data(m_data[0]), .m0_mask(m_mask[0]), .m0_credit(m0_credit),
		.m1_clk(m1_clk), .m1_rst_b(m1_rst_b), .m1_valid(m_valid[1]), .m1_mode(m_mode[1]),
		.m1_did(m_did[1]), .m1_subdid(m_subdid[1]), .m1_addr(m_addr[1]), .m1_len(m_len[1]),
		.m1_data(m_data[1]), .m1_mask(m_mask[1]), .m1_credit(m1_credit),
		.out_valid(out_valid), .out_mode(out_mode), .out_did(out_did),
		.out_subdid(out_subdid), .out_addr(out_addr), .out_len(out_len),
		.out_data(out_data), .out_mask(out_mask)
	);

	bind fsab_arbiter_fifo fsab_arb_checker u_checker (
		.iclk(iclk), .iclk_rst_b(iclk_rst_b), .oclk(oclk), .oclk_rst_b(oclk_rst_b),
		.inp_hdr(inp_hdr), .inp_valid(inp_valid), .rfif_rd(rfif_rd), .dfif_rd(dfif_rd),
		.start_trans(start_trans), .active(active)
	);

	initial begin
		oclk = 1'b0;
		forever #4 oclk = ~oclk;
	end

	initial begin
		m0_clk = 1'b0;
		forever #5 m0_clk = ~m0_clk;
	end

	initial begin
		m1_clk = 1'b0;
		forever #3 m1_clk = ~m1_clk;
	end

	// Expected bus beat for one master word. Header held for the whole burst.
	function automatic beat_t expected_beat(fsab_mode_t mode, fsab_did_t did,
		fsab_did_t subdid, fsab_addr_t addr, fsab_len_t len, fsab_data_t data,
		fsab_mask_t mask);
		beat_t b;
		b.mode = mode;
		b.did = did;
		b.subdid = subdid;
		b.addr = addr;
		b.len = len;
		b.data = (mode == fsab_write) ? data : '0; // Read beat carries no data.
		b.mask = (mode == fsab_write) ? mask : '0;
		return b;
	endfunction

	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	// Returns just past the master's rising edge.
	task automatic wait_master_clk(input int idx);
		if (idx == 0)
			@(posedge m0_clk);
		else
			@(posedge m1_clk);
		#1;
	endtask

	task automatic send_request(input int idx, input fsab_mode_t mode, input int len,
		input int max_gap);
		int cycles;
		int beats;
		int gap;
		int b;
		fsab_did_t subdid;
		fsab_addr_t addr;
		beat_t exp;
		cycles = 0;
		wait_master_clk(idx);
		if (credits[idx] == 0)
			stalls[idx]++;
		while ((credits[idx] == 0) && (cycles < credit_timeout)) begin
			wait_master_clk(idx);
			cycles++;
		end
		if (credits[idx] == 0) begin
			$display("%s: master %0d got no credit back in time", cur_test, idx);
			errors++;
			return;
		end
		credits[idx]--; // Spent at the header.
		subdid = fsab_did_t'($urandom);
		addr = $urandom;
		beats = (mode == fsab_write) ? len : 1;
		for (b = 0; b < beats; b++) begin
			gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
			if (gap > 0) begin
				m_valid[idx] = 1'b0;
				repeat (gap) wait_master_clk(idx);
			end
			m_valid[idx] = 1'b1;
			if (b == 0) begin
				m_mode[idx] = mode;
				m_subdid[idx] = subdid;
				m_addr[idx] = addr;
				m_len[idx] = fsab_len_t'(len);
			end else begin // Header ignored here, so scramble it.
				m_mode[idx] = fsab_mode_t'($urandom_range(1, 0));
				m_subdid[idx] = fsab_did_t'($urandom);
				m_addr[idx] = $urandom;
				m_len[idx] = fsab_len_t'($urandom);
			end
			m_data[idx] = {$urandom, $urandom};
			m_mask[idx] = fsab_mask_t'($urandom);
			exp = expected_beat(mode, fsab_did_t'(idx), subdid, addr, fsab_len_t'(len),
				m_data[idx], m_mask[idx]);
			if (idx == 0)
				exp_q0.push_back(exp);
			else
				exp_q1.push_back(exp);
			wait_master_clk(idx);
		end
		m_valid[idx] = 1'b0;
	endtask

	task automatic send_random(input int idx, input int count, input int max_gap);
		int n;
		for (n = 0; n < count; n++)
			send_request(idx, fsab_mode_t'($urandom_range(1, 0)), $urandom_range(8, 1),
				max_gap);
	endtask

	// Waits for all beats and credits, then watches for stray beats.
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (((exp_q0.size() != 0) || (exp_q1.size() != 0) ||
			(credits[0] < fsab_initial_credits) || (credits[1] < fsab_initial_credits)) &&
			(cycles < drain_timeout)) begin
			@(posedge oclk);
			cycles++;
		end
		if (cycles >= drain_timeout) begin
			$display("%s: timed out waiting for beats and credits to come back", cur_test);
			errors++;
		end
		repeat (30) @(posedge oclk);
		check_value("m0 credits", fsab_initial_credits, credits[0]);
		check_value("m1 credits", fsab_initial_credits, credits[1]);
		check_value("m0 beats missing", 0, exp_q0.size());
		check_value("m1 beats missing", 0, exp_q1.size());
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors) begin
			$display("PASS %s", cur_test);
		end else begin
			$display("FAIL %s with %0d errors", cur_test, errors - test_errors);
			tests_failed++;
		end
	endtask

	// Credit pulses are stable mid-cycle.
	always @(negedge m0_clk)
		if ((m0_rst_b === 1'b1) && (m0_credit === 1'b1))
			credits[0] = credits[0] + 1;

	always @(negedge m1_clk)
		if ((m1_rst_b === 1'b1) && (m1_credit === 1'b1))
			credits[1] = credits[1] + 1;

	// Scoreboard, one queue per did.
	always @(negedge oclk) begin : compare_beats
		beat_t exp;
		logic found;
		if (oclk_rst_b === 1'b1) begin
			check_value("start_trans one-hot", 1, $onehot0(u_fsab_arb_top.start_trans));
			if (out_valid === 1'b1) begin
				found = 1'b1;
				if ((out_did == 4'd0) && (exp_q0.size() != 0))
					exp = exp_q0.pop_front();
				else if ((out_did == 4'd1) && (exp_q1.size() != 0))
					exp = exp_q1.pop_front();
				else
					found = 1'b0;
				if (!found) begin
					$display("%s: bus beat from did %0d with no request pending",
						cur_test, out_did);
					errors++;
					burst_left = 0;
				end else begin
					if (burst_left == 0) begin // First beat of a request.
						burst_did = out_did;
						burst_left = (exp.mode == fsab_write) ? int'(exp.len) : 1;
					end
					check_value("did within burst", burst_did, out_did);
					burst_left--;
					check_value("header", {exp.mode, exp.did, exp.subdid, exp.addr, exp.len},
						{out_mode, out_did, out_subdid, out_addr, out_len});
					if (exp.mode == fsab_write) begin
						check_value("data", exp.data, out_data);
						check_value("mask", exp.mask, out_mask);
					end
				end
			end
		end
	end

	initial begin : main
		int len;
		void'($urandom(60274));
		oclk_rst_b = 1'b0;
		m0_rst_b = 1'b0;
		m1_rst_b = 1'b0;
		for (int i = 0; i < 2; i++) begin
			m_valid[i] = 1'b0;
			m_mode[i] = fsab_read;
			m_did[i] = fsab_did_t'(i); // Fixed per master.
			m_subdid[i] = '0;
			m_addr[i] = '0;
			m_len[i] = '0;
			m_data[i] = '0;
			m_mask[i] = '0;
			credits[i] = fsab_initial_credits;
			stalls[i] = 0;
		end
		fork
			begin
				repeat (8) @(posedge oclk);
				#1 oclk_rst_b = 1'b1;
			end
			begin
				repeat (8) @(posedge m0_clk);
				#1 m0_rst_b = 1'b1;
			end
			begin
				repeat (8) @(posedge m1_clk);
				#1 m1_rst_b = 1'b1;
			end
		join

		start_test("reset_idle");
		repeat (40) begin
			@(negedge oclk);
			check_value("out_valid", 0, out_valid);
			check_value("m0_credit", 0, m0_credit);
			check_value("m1_credit", 0, m1_credit);
		end
		end_test();

		start_test("write_lengths");
		for (len = 1; len <= fsab_len_max; len++)
			send_request(0, fsab_write, len, 0);
		wait_drain();
		end_test();

		start_test("reads");
		fork
			for (int n = 0; n < 3; n++) send_request(0, fsab_read, $urandom_range(8, 1), 1);
			for (int n = 0; n < 3; n++) send_request(1, fsab_read, $urandom_range(8, 1), 1);
		join
		wait_drain();
		end_test();

		start_test("concurrent");
		fork
			send_random(0, 16, 3);
			send_random(1, 16, 3);
		join
		wait_drain();
		end_test();

		start_test("credit_stall");
		stalls[0] = 0;
		stalls[1] = 0;
		fork
			for (int n = 0; n < 8; n++) send_request(0, fsab_read, 1, 0);
			for (int n = 0; n < 8; n++) send_request(1, fsab_write, fsab_len_max, 0);
		join
		wait_drain();
		check_value("m0 stalled for credit", 1, stalls[0] > 0);
		check_value("m1 stalled for credit", 1, stalls[1] > 0);
		end_test();

		$display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if ((errors == 0) && (tests_failed == 0)) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end
endmodule
